// File: include/dbg_consts.svh
// debug interconnect constants
// word width, packet type and subtype codes, register map and module identity
`ifndef DBG_CONSTS_SVH
`define DBG_CONSTS_SVH

// packet word width, fixed by the packet format
`define DBG_W 16
`define DBG_TYPE_W 2
`define DBG_SUB_W 4

// flags word type field, zero marks a register access
`define DBG_TYPE_REG 2'd0

// request subtypes
`define DBG_SUB_REQ_READ 4'd0
`define DBG_SUB_REQ_WRITE 4'd1

// response subtypes, error variants carry no data word
`define DBG_SUB_RESP_READ 4'd2
`define DBG_SUB_RESP_WRITE 4'd3
`define DBG_SUB_RESP_READ_ERR 4'd4
`define DBG_SUB_RESP_WRITE_ERR 4'd5

// register map
`define DBG_REG_MOD_ID 16'h0000
`define DBG_REG_VERSION 16'h0001
`define DBG_REG_SCRATCH 16'h0200
`define DBG_REG_CONTROL 16'h0201

// read-only identity values
`define DBG_MOD_ID_VAL 16'h0005
`define DBG_VERSION_VAL 16'h0001

`endif

// File: verilog/dbg_pkg.sv
// debug interconnect types
// stream word struct and the two decodings of the flags word
`default_nettype none

`include "dbg_consts.svh"

package dbg_pkg;

  // one packet word, valid and ready travel beside it
  typedef struct packed {
    logic [`DBG_W-1:0] data;
    logic              last;
  } dbg_flit_t;

  // flags word as seen by the demux, only the type matters
  typedef struct packed {
    logic [`DBG_TYPE_W-1:0]         pkt_type;
    logic [`DBG_W-`DBG_TYPE_W-1:0]  opaque;
  } dbg_flags_generic_t;

  // flags word of a register access request or response
  typedef struct packed {
    logic [`DBG_TYPE_W-1:0]                     pkt_type;
    logic [`DBG_SUB_W-1:0]                      subtype;
    logic [`DBG_W-`DBG_TYPE_W-`DBG_SUB_W-1:0]   reserved;
  } dbg_flags_reg_t;

  // same 16 bits, two views
  typedef union packed {
    dbg_flags_generic_t generic;
    dbg_flags_reg_t     reg_hdr;
  } dbg_flags_u;

endpackage

`default_nettype wire

// File: verilog/dbg_regaccess_demux.sv
// register access demux
// buffers three words, tags the packet by its flags type and steers it
// to the register unit or the bypass port
`default_nettype none

`include "dbg_consts.svh"

module dbg_regaccess_demux
  import dbg_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  dbg_flit_t in,
  input  logic      in_valid,
  output logic      in_ready,
  output dbg_flit_t reg_out,
  output logic      reg_out_valid,
  input  logic      reg_out_ready,
  output dbg_flit_t bypass_out,
  output logic      bypass_out_valid,
  input  logic      bypass_out_ready
);

  // one buffer slot with its routing tags
  typedef struct packed {
    dbg_flit_t flit;
    logic      valid;
    logic      is_reg;
    logic      is_byp;
  } stage_t;

  // slot 0 is the input stage, slot 2 is the head
  stage_t     stage [3];
  dbg_flags_u flags;
  logic       do_tag;
  logic       mark_reg;
  logic       mark_byp;
  logic       pkt_reg;
  logic       pkt_byp;
  logic       hold_1;
  logic       hold_2;
  logic       none_tagged;
  logic       head_reg;
  logic       head_byp;

  // holds a word that no packet decision has reached yet
  function automatic logic untagged(stage_t s);
    return s.valid & !s.is_reg & !s.is_byp;
  endfunction

  // flags word sits in the input stage once three words are buffered
  assign flags    = stage[0].flit.data;
  assign do_tag   = untagged(stage[0]) & untagged(stage[1]) & untagged(stage[2]);
  assign mark_reg = do_tag & (flags.generic.pkt_type == `DBG_TYPE_REG);
  assign mark_byp = do_tag & (flags.generic.pkt_type != `DBG_TYPE_REG);

  // untagged words compact toward the head while waiting for the flags word
  assign hold_2 = !do_tag & untagged(stage[2]);
  assign hold_1 = hold_2 & untagged(stage[1]);

  // remember the decision for words of this packet still to come
  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_reg <= 1'b0;
      pkt_byp <= 1'b0;
    end else begin
      pkt_reg <= (pkt_reg | mark_reg) & !(in_valid & in_ready & in.last)
                 & !(stage[0].valid & stage[0].flit.last);
      pkt_byp <= (pkt_byp | mark_byp) & !(in_valid & in_ready & in.last)
                 & !(stage[0].valid & stage[0].flit.last);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 3; i++) begin
        stage[i].valid  <= 1'b0;
        stage[i].is_reg <= 1'b0;
        stage[i].is_byp <= 1'b0;
      end
    end else if (in_ready) begin
      stage[0].flit  <= in;
      stage[0].valid <= in_valid;
      // a word after a non-last word continues the current packet
      if (stage[0].valid & !stage[0].flit.last) begin
        stage[0].is_reg <= pkt_reg | mark_reg;
        stage[0].is_byp <= pkt_byp | mark_byp;
      end else begin
        stage[0].is_reg <= pkt_reg;
        stage[0].is_byp <= pkt_byp;
      end

      if (!hold_1) begin
        stage[1].flit   <= stage[0].flit;
        stage[1].valid  <= stage[0].valid;
        stage[1].is_reg <= stage[0].is_reg | mark_reg;
        stage[1].is_byp <= stage[0].is_byp | mark_byp;
      end

      if (!hold_2) begin
        stage[2].flit   <= stage[1].flit;
        stage[2].valid  <= stage[1].valid;
        stage[2].is_reg <= stage[1].is_reg | mark_reg;
        stage[2].is_byp <= stage[1].is_byp | mark_byp;
      end
    end
  end

  // head is offered in the same cycle the tag is decided
  assign head_reg = stage[2].is_reg | mark_reg;
  assign head_byp = stage[2].is_byp | mark_byp;

  assign reg_out          = stage[2].flit;
  assign reg_out_valid    = stage[2].valid & head_reg;
  assign bypass_out       = stage[2].flit;
  assign bypass_out_valid = stage[2].valid & head_byp;

  // stall only when the tagged packet's own port is blocked
  assign none_tagged = !do_tag & !stage[0].is_reg & !stage[0].is_byp
                       & !stage[1].is_reg & !stage[1].is_byp
                       & !stage[2].is_reg & !stage[2].is_byp;
  assign in_ready = (reg_out_ready & bypass_out_ready)
                    | (reg_out_ready & head_reg)
                    | (bypass_out_ready & head_byp)
                    | none_tagged;

endmodule

`default_nettype wire

// File: verilog/dbg_regaccess.sv
// register access unit
// parses read and write requests, owns the scratch and control registers
// and serializes the response packet
`default_nettype none

`include "dbg_consts.svh"

module dbg_regaccess
  import dbg_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  dbg_flit_t req,
  input  logic      req_valid,
  output logic      req_ready,
  output dbg_flit_t resp,
  output logic      resp_valid,
  input  logic      resp_ready,
  output logic      ctrl_enable
);

  typedef enum logic {
    ST_REQ,
    ST_RESP
  } state_t;

  state_t                state;
  logic [2:0]            idx;
  logic [1:0]            ridx;
  logic [`DBG_W-1:0]     dst_q;
  logic [`DBG_W-1:0]     src_q;
  logic [`DBG_W-1:0]     addr_q;
  logic [`DBG_SUB_W-1:0] sub_q;
  logic [`DBG_SUB_W-1:0] cur_sub;
  logic [`DBG_SUB_W-1:0] rsp_sub;
  logic [`DBG_W-1:0]     rsp_data;
  logic                  rsp_has_data;
  logic [`DBG_W-1:0]     scratch_q;
  logic                  ctrl_q;
  dbg_flags_u            req_flags;
  dbg_flags_u            resp_flags;
  logic                  req_fire;
  logic                  req_end;
  logic                  resp_fire;
  logic                  rd_hit;
  logic [`DBG_W-1:0]     rd_val;
  logic                  wr_hit;
  logic                  is_write;
  logic                  rd_ok;
  logic                  wr_ok;

  assign req_ready = (state == ST_REQ);
  assign req_fire  = req_valid & req_ready;
  assign req_end   = req_fire & req.last;
  assign req_flags = req.data;

  // subtype is still on the bus if the packet ends at the flags word
  assign cur_sub  = (idx == 3'd2) ? req_flags.reg_hdr.subtype : sub_q;
  assign is_write = (cur_sub == `DBG_SUB_REQ_WRITE);

  // read decode on the address word itself, a good read ends there
  always_comb begin
    rd_hit = 1'b1;
    case (req.data)
      `DBG_REG_MOD_ID:  rd_val = `DBG_MOD_ID_VAL;
      `DBG_REG_VERSION: rd_val = `DBG_VERSION_VAL;
      `DBG_REG_SCRATCH: rd_val = scratch_q;
      `DBG_REG_CONTROL: rd_val = {{(`DBG_W-1){1'b0}}, ctrl_q};
      default: begin
        rd_hit = 1'b0;
        rd_val = '0;
      end
    endcase
  end

  // only scratch and control accept writes
  assign wr_hit = (addr_q == `DBG_REG_SCRATCH) | (addr_q == `DBG_REG_CONTROL);

  // length check is folded in through the index of the last word
  assign rd_ok = (idx == 3'd3) & (cur_sub == `DBG_SUB_REQ_READ) & rd_hit;
  assign wr_ok = (idx == 3'd4) & is_write & wr_hit;

  // capture header words as they pass, no reset needed on payload
  always_ff @(posedge clk) begin
    if (req_fire) begin
      case (idx)
        3'd0: dst_q <= req.data;
        3'd1: src_q <= req.data;
        3'd2: sub_q <= req_flags.reg_hdr.subtype;
        3'd3: addr_q <= req.data;
        default: ;
      endcase
    end
    if (req_end) begin
      rsp_data     <= rd_val;
      rsp_has_data <= rd_ok;
      if (rd_ok) begin
        rsp_sub <= `DBG_SUB_RESP_READ;
      end else if (wr_ok) begin
        rsp_sub <= `DBG_SUB_RESP_WRITE;
      end else if (is_write) begin
        rsp_sub <= `DBG_SUB_RESP_WRITE_ERR;
      end else begin
        rsp_sub <= `DBG_SUB_RESP_READ_ERR;
      end
    end
  end

  // request word index saturates, overlong packets still count as long
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_REQ;
      idx   <= 3'd0;
      ridx  <= 2'd0;
    end else begin
      if (req_end) begin
        state <= ST_RESP;
        idx   <= 3'd0;
      end else if (req_fire && idx != 3'd5) begin
        idx <= idx + 3'd1;
      end
      if (resp_fire) begin
        if (resp.last) begin
          state <= ST_REQ;
          ridx  <= 2'd0;
        end else begin
          ridx <= ridx + 2'd1;
        end
      end
    end
  end

  // register file, written on the data word of a good write
  always_ff @(posedge clk) begin
    if (rst) begin
      scratch_q <= '0;
      ctrl_q    <= 1'b0;
    end else if (req_end && wr_ok) begin
      if (addr_q == `DBG_REG_SCRATCH) begin
        scratch_q <= req.data;
      end else begin
        ctrl_q <= req.data[0];
      end
    end
  end

  assign ctrl_enable = ctrl_q;

  // response flags word, type zero plus the decided subtype
  always_comb begin
    resp_flags.reg_hdr.pkt_type = `DBG_TYPE_REG;
    resp_flags.reg_hdr.subtype  = rsp_sub;
    resp_flags.reg_hdr.reserved = '0;
  end

  // source and destination swap places in the response
  always_comb begin
    case (ridx)
      2'd0:    resp.data = src_q;
      2'd1:    resp.data = dst_q;
      2'd2:    resp.data = resp_flags;
      default: resp.data = rsp_data;
    endcase
    resp.last = rsp_has_data ? (ridx == 2'd3) : (ridx == 2'd2);
  end

  assign resp_valid = (state == ST_RESP);
  assign resp_fire  = resp_valid & resp_ready;

endmodule

`default_nettype wire

// File: verilog/dbg_stream_arb.sv
// packet-atomic round-robin merge of two debug streams
// the granted source passes through with no added latency
`default_nettype none

module dbg_stream_arb
  import dbg_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  dbg_flit_t a_in,
  input  logic      a_valid,
  output logic      a_ready,
  input  dbg_flit_t b_in,
  input  logic      b_valid,
  output logic      b_ready,
  output dbg_flit_t out,
  output logic      out_valid,
  input  logic      out_ready
);

  // locked while a packet is in flight or a word is offered but not taken
  logic locked;
  // 1 when b holds or last held the grant
  logic last_b;
  logic grant_b;
  logic out_fire;

  always_comb begin
    if (locked) begin
      grant_b = last_b;
    end else if (a_valid && b_valid) begin
      // both waiting, the source not served last goes first
      grant_b = !last_b;
    end else begin
      grant_b = b_valid;
    end
  end

  assign out       = grant_b ? b_in : a_in;
  assign out_valid = grant_b ? b_valid : a_valid;
  assign a_ready   = !grant_b & out_ready;
  assign b_ready   = grant_b & out_ready;
  assign out_fire  = out_valid & out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      locked <= 1'b0;
      last_b <= 1'b0;
    end else begin
      // an offered word pins the grant so the output stays stable
      locked <= (locked | out_valid) & !(out_fire & out.last);
      if (out_valid) begin
        last_b <= grant_b;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/dbg_access_top.sv
// debug register access front end
// demux to register unit or bypass, responses merged with module events
`default_nettype none

module dbg_access_top
  import dbg_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  dbg_flit_t debug_in,
  input  logic      debug_in_valid,
  output logic      debug_in_ready,
  output dbg_flit_t debug_out,
  output logic      debug_out_valid,
  input  logic      debug_out_ready,
  output dbg_flit_t bypass_out,
  output logic      bypass_out_valid,
  input  logic      bypass_out_ready,
  input  dbg_flit_t event_in,
  input  logic      event_in_valid,
  output logic      event_in_ready,
  output logic      ctrl_enable
);

  // demux to register unit
  dbg_flit_t reg_req;
  logic      reg_req_valid;
  logic      reg_req_ready;
  // register unit to arbiter
  dbg_flit_t reg_resp;
  logic      reg_resp_valid;
  logic      reg_resp_ready;

  dbg_regaccess_demux u_demux (
    .clk              (clk),
    .rst              (rst),
    .in               (debug_in),
    .in_valid         (debug_in_valid),
    .in_ready         (debug_in_ready),
    .reg_out          (reg_req),
    .reg_out_valid    (reg_req_valid),
    .reg_out_ready    (reg_req_ready),
    .bypass_out       (bypass_out),
    .bypass_out_valid (bypass_out_valid),
    .bypass_out_ready (bypass_out_ready)
  );

  dbg_regaccess u_regaccess (
    .clk         (clk),
    .rst         (rst),
    .req         (reg_req),
    .req_valid   (reg_req_valid),
    .req_ready   (reg_req_ready),
    .resp        (reg_resp),
    .resp_valid  (reg_resp_valid),
    .resp_ready  (reg_resp_ready),
    .ctrl_enable (ctrl_enable)
  );

  // source a carries register responses, b carries module events
  dbg_stream_arb u_arb (
    .clk       (clk),
    .rst       (rst),
    .a_in      (reg_resp),
    .a_valid   (reg_resp_valid),
    .a_ready   (reg_resp_ready),
    .b_in      (event_in),
    .b_valid   (event_in_valid),
    .b_ready   (event_in_ready),
    .out       (debug_out),
    .out_valid (debug_out_valid),
    .out_ready (debug_out_ready)
  );

endmodule

`default_nettype wire

// File: verif/dbg_access_checker.sv
// stream protocol checker for the debug register access front end
// bound to the top level, reports through failing assertions only
`default_nettype none

module dbg_access_checker
  import dbg_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input dbg_flit_t debug_in,
  input logic      debug_in_valid,
  input logic      debug_in_ready,
  input dbg_flit_t debug_out,
  input logic      debug_out_valid,
  input logic      debug_out_ready,
  input dbg_flit_t bypass_out,
  input logic      bypass_out_valid,
  input logic      bypass_out_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  // number of failed assertions, read by the testbench at the end
  int unsigned assert_fails = 0;
  // words of the current debug_in packet taken so far, saturates at 3
  logic [1:0] in_words;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_words <= 2'd0;
    end else if (debug_in_valid && debug_in_ready) begin
      if (debug_in.last) begin
        in_words <= 2'd0;
      end else if (in_words != 2'd3) begin
        in_words <= in_words + 2'd1;
      end
    end
  end

  // a stalled word stays offered and unchanged until taken
  debug_out_hold: assert property (@(posedge clk) disable iff (rst)
      debug_out_valid && !debug_out_ready |=> debug_out_valid && $stable(debug_out))
    else begin
      assert_fails++;
      $error("debug_out word changed or dropped while stalled");
    end

  bypass_out_hold: assert property (@(posedge clk) disable iff (rst)
      bypass_out_valid && !bypass_out_ready |=> bypass_out_valid && $stable(bypass_out))
    else begin
      assert_fails++;
      $error("bypass_out word changed or dropped while stalled");
    end

  // first reset edge loads the registers, from then on outputs stay quiet
  reset_quiet: assert property (@(posedge clk)
      rst && $past(rst) |-> !debug_out_valid && !bypass_out_valid)
    else begin
      assert_fails++;
      $error("valid output raised during reset");
    end

  // the demux needs the flags word, so packets carry at least 3 words
  min_length: assert property (@(posedge clk) disable iff (rst)
      debug_in_valid && debug_in_ready && debug_in.last |-> in_words >= 2'd2)
    else begin
      assert_fails++;
      $error("debug_in packet shorter than 3 words");
    end

endmodule

bind dbg_access_top dbg_access_checker u_checker (
  .clk              (clk),
  .rst              (rst),
  .debug_in         (debug_in),
  .debug_in_valid   (debug_in_valid),
  .debug_in_ready   (debug_in_ready),
  .debug_out        (debug_out),
  .debug_out_valid  (debug_out_valid),
  .debug_out_ready  (debug_out_ready),
  .bypass_out       (bypass_out),
  .bypass_out_valid (bypass_out_valid),
  .bypass_out_ready (bypass_out_ready)
);

`default_nettype wire

// File: verif/dbg_access_tb.sv
// testbench for the debug register access front end
// file-driven requests and events, random sink back-pressure, per-port checks
`default_nettype none

module dbg_access_tb
  import dbg_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_REC = 32;
  localparam int REC_W = 17;

  logic      clk;
  logic      rst;
  dbg_flit_t debug_in;
  logic      debug_in_valid;
  logic      debug_in_ready;
  dbg_flit_t debug_out;
  logic      debug_out_valid;
  logic      debug_out_ready;
  dbg_flit_t bypass_out;
  logic      bypass_out_valid;
  logic      bypass_out_ready;
  dbg_flit_t event_in;
  logic      event_in_valid;
  logic      event_in_ready;
  logic      ctrl_enable;

  // columns: kind n_in n_out port ctrl in0..in5 out0..out5
  logic [15:0] stim [MAX_REC * REC_W];
  int          n_rec = 0;
  int          limit = 0;
  int          cycles = 0;
  int          err_count = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  int          tests_done = 0;
  int          test_err [MAX_REC];
  // source of the packet in progress on debug_out, -1 between packets
  int          out_src = -1;
  // expected words as {data, last}, one queue per source of output
  logic [16:0] exp_resp [$];
  logic [16:0] exp_event [$];
  logic [16:0] exp_byp [$];
  // record index of the packet at the front of each queue
  int          id_resp [$];
  int          id_event [$];
  int          id_byp [$];

  dbg_access_top DUT (
    .clk              (clk),
    .rst              (rst),
    .debug_in         (debug_in),
    .debug_in_valid   (debug_in_valid),
    .debug_in_ready   (debug_in_ready),
    .debug_out        (debug_out),
    .debug_out_valid  (debug_out_valid),
    .debug_out_ready  (debug_out_ready),
    .bypass_out       (bypass_out),
    .bypass_out_valid (bypass_out_valid),
    .bypass_out_ready (bypass_out_ready),
    .event_in         (event_in),
    .event_in_valid   (event_in_valid),
    .event_in_ready   (event_in_ready),
    .ctrl_enable      (ctrl_enable)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [15:0] stim_word(input int rec, input int col);
    return stim[rec * REC_W + col];
  endfunction

  function automatic string kind_name(input int k);
    case (k)
      0: return "read";
      1: return "write";
      2: return "bypass";
      default: return "event";
    endcase
  endfunction

  task automatic check_value(input int rec, input logic [16:0] got, input logic [16:0] want,
                             input string what);
    if (got !== want) begin
      $display("[ERROR] %0t: %s got %h last %b, expected %h last %b", $time, what,
               got[16:1], got[0], want[16:1], want[0]);
      err_count++;
      if (rec >= 0) begin
        test_err[rec]++;
      end
    end
  endtask

  // queue the expected output packet of a record on its port
  task automatic push_expected(input int rec);
    int          n;
    int          k;
    logic [16:0] want;
    n = int'(stim_word(rec, 2));
    k = int'(stim_word(rec, 0));
    if (stim_word(rec, 3) == 16'd1) begin
      id_byp.push_back(rec);
    end else if (k == 3) begin
      id_event.push_back(rec);
    end else begin
      id_resp.push_back(rec);
    end
    for (int i = 0; i < n; i++) begin
      want = {stim_word(rec, 11 + i), i == n - 1};
      if (stim_word(rec, 3) == 16'd1) begin
        exp_byp.push_back(want);
      end else if (k == 3) begin
        exp_event.push_back(want);
      end else begin
        exp_resp.push_back(want);
      end
    end
  endtask

  // each word holds until a negedge sees ready, then moves on after the edge
  task automatic drive_debug_packet(input int rec);
    int   n;
    logic taken;
    n = int'(stim_word(rec, 1));
    for (int i = 0; i < n; i++) begin
      debug_in.data = stim_word(rec, 5 + i);
      debug_in.last = (i == n - 1);
      debug_in_valid = 1'b1;
      do begin
        @(negedge clk);
        taken = debug_in_ready;
        @(posedge clk);
        #1;
      end while (!taken);
    end
    debug_in_valid = 1'b0;
  endtask

  task automatic drive_event_packet(input int rec);
    int   n;
    logic taken;
    n = int'(stim_word(rec, 1));
    for (int i = 0; i < n; i++) begin
      event_in.data = stim_word(rec, 5 + i);
      event_in.last = (i == n - 1);
      event_in_valid = 1'b1;
      do begin
        @(negedge clk);
        taken = event_in_ready;
        @(posedge clk);
        #1;
      end while (!taken);
    end
    event_in_valid = 1'b0;
  endtask

  task automatic finish_test(input int rec);
    int          k;
    logic [15:0] ctrl_want;
    k = int'(stim_word(rec, 0));
    ctrl_want = stim_word(rec, 4);
    // register writes land before their response, so ctrl_enable is settled
    if (k < 2) begin
      check_value(rec, {16'h0, ctrl_enable}, {16'h0, ctrl_want[0]}, "ctrl_enable");
    end
    tests_done++;
    if (test_err[rec] == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    $display("test %0d %s: %s", rec, kind_name(k), (test_err[rec] == 0) ? "passed" : "failed");
  endtask

  // src 0 register response, 1 event, 2 bypass
  task automatic take_word(input int src, input logic [16:0] got);
    logic [16:0] want;
    int          rec;
    logic        found;
    found = 1'b0;
    if (src == 0 && exp_resp.size() != 0) begin
      want = exp_resp.pop_front();
      rec = id_resp[0];
      if (want[0]) id_resp.delete(0);
      found = 1'b1;
    end else if (src == 1 && exp_event.size() != 0) begin
      want = exp_event.pop_front();
      rec = id_event[0];
      if (want[0]) id_event.delete(0);
      found = 1'b1;
    end else if (src == 2 && exp_byp.size() != 0) begin
      want = exp_byp.pop_front();
      rec = id_byp[0];
      if (want[0]) id_byp.delete(0);
      found = 1'b1;
    end
    if (!found) begin
      $display("unexpected word %h on output %0d at %0t with no packet pending",
               got[16:1], src, $time);
      err_count++;
    end else begin
      check_value(rec, got, want, (src == 2) ? "bypass_out word" : "debug_out word");
      if (want[0]) finish_test(rec);
    end
  endtask

  // a debug_out packet runs to its last word before the other source gets in
  task automatic track_out_packet(input int src, input logic last);
    if (out_src >= 0 && src != out_src) begin
      $display("debug_out packet split: source %0d word at %0t inside a source %0d packet",
               src, $time, out_src);
      err_count++;
    end
    out_src = last ? -1 : src;
  endtask

  // sample handshakes at negedge, away from the drive and the clock edge
  always @(negedge clk) begin
    if (!rst) begin
      if (debug_out_valid && debug_out_ready) begin
        // the arbiter passes events through, so an event handshake names the source
        if (event_in_valid && event_in_ready) begin
          track_out_packet(1, debug_out.last);
          take_word(1, debug_out);
        end else begin
          track_out_packet(0, debug_out.last);
          take_word(0, debug_out);
        end
      end
      if (bypass_out_valid && bypass_out_ready) begin
        take_word(2, bypass_out);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: run stopped after %0d cycles, %0d of %0d tests finished",
               cycles, tests_done, n_rec);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // sink back-pressure, ready about three cycles in four
  initial begin
    debug_out_ready = 1'b0;
    bypass_out_ready = 1'b0;
    void'($urandom(2069));
    forever begin
      @(posedge clk);
      #1;
      debug_out_ready = ($urandom % 4) != 0;
      bypass_out_ready = ($urandom % 4) != 0;
    end
  end

  initial begin
    rst = 1'b1;
    debug_in = '0;
    debug_in_valid = 1'b0;
    event_in = '0;
    event_in_valid = 1'b0;
    $readmemh("verif/dbg_stimulus.txt", stim);
    while (n_rec < MAX_REC && stim[n_rec * REC_W] != 16'hffff) begin
      n_rec++;
    end
    limit = 200 * n_rec + 100;
    if (n_rec == 0) begin
      $display("no test records were read from the stimulus file");
      err_count++;
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value(-1, {16'h0, ctrl_enable}, 17'h0, "ctrl_enable after reset");
    fork
      begin
        for (int r = 0; r < n_rec; r++) begin
          if (stim_word(r, 0) != 16'd3) begin
            push_expected(r);
            drive_debug_packet(r);
            repeat (r % 3) begin
              @(posedge clk);
              #1;
            end
          end
        end
      end
      begin
        for (int r = 0; r < n_rec; r++) begin
          if (stim_word(r, 0) == 16'd3) begin
            push_expected(r);
            drive_event_packet(r);
            repeat (r % 2) begin
              @(posedge clk);
              #1;
            end
          end
        end
      end
    join
    wait (tests_done == n_rec);
    repeat (5) @(posedge clk);
    $display("tests passed: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
             n_pass, n_fail, err_count, DUT.u_checker.assert_fails);
    if (n_fail == 0 && err_count == 0 && DUT.u_checker.assert_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/dbg_stimulus.txt
// kind(0 read,1 write,2 bypass,3 event) n_in n_out port(0 debug_out,1 bypass_out) ctrl
// then input words in0..in5 and expected output words out0..out5, ffff kind ends the list
0000 0004 0004 0000 0000 0010 0020 0000 0000 0000 0000 0020 0010 0800 0005 0000 0000
0003 0004 0004 0000 0000 0050 0060 c001 dead 0000 0000 0050 0060 c001 dead 0000 0000
0000 0004 0004 0000 0000 0011 0021 0000 0001 0000 0000 0021 0011 0800 0001 0000 0000
0001 0005 0003 0000 0000 0012 0022 0400 0200 a5c3 0000 0022 0012 0c00 0000 0000 0000
0002 0006 0006 0001 0000 0030 0040 4000 1111 2222 3333 0030 0040 4000 1111 2222 3333
0000 0004 0004 0000 0000 0013 0023 0000 0200 0000 0000 0023 0013 0800 a5c3 0000 0000
0003 0003 0003 0000 0000 0051 0061 c002 0000 0000 0000 0051 0061 c002 0000 0000 0000
0001 0005 0003 0000 0001 0014 0024 0400 0201 ffff 0000 0024 0014 0c00 0000 0000 0000
0000 0004 0004 0000 0001 0015 0025 0000 0201 0000 0000 0025 0015 0800 0001 0000 0000
0002 0003 0003 0001 0000 0031 0041 8000 0000 0000 0000 0031 0041 8000 0000 0000 0000
0000 0004 0003 0000 0001 0016 0026 0000 0300 0000 0000 0026 0016 1000 0000 0000 0000
0003 0005 0005 0000 0000 0052 0062 c003 0001 0002 0000 0052 0062 c003 0001 0002 0000
0001 0005 0003 0000 0001 0017 0027 0400 0001 1234 0000 0027 0017 1400 0000 0000 0000
0000 0005 0003 0000 0001 0018 0028 0000 0000 beef 0000 0028 0018 1000 0000 0000 0000
0002 0004 0004 0001 0000 0032 0042 c0ff 5a5a 0000 0000 0032 0042 c0ff 5a5a 0000 0000
0003 0004 0004 0000 0000 0053 0063 c004 0bad 0000 0000 0053 0063 c004 0bad 0000 0000
0000 0004 0004 0000 0001 0019 0029 0000 0200 0000 0000 0029 0019 0800 a5c3 0000 0000
ffff 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000

// File: sources.f
+incdir+include
verilog/dbg_pkg.sv
verilog/dbg_regaccess_demux.sv
verilog/dbg_regaccess.sv
verilog/dbg_stream_arb.sv
verilog/dbg_access_top.sv
verif/dbg_access_checker.sv
verif/dbg_access_tb.sv

// File: Makefile
TOP := dbg_access_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
